// ==== Bender.yml ====
package:
  name: mcu_buffer

sources:
  # package and interface ahead of the modules that use them
  - files:
      - design/jpeg_mcu_pkg.sv
      - design/ram_wr_if.sv
      - design/line_ram_be.sv
      - design/pixel_writer.sv
      - design/mcu_reader.sv
      - design/mcu_buffer.sv
  - target: test
    files:
      - dv/mcu_buffer_tb.sv

// ==== design/jpeg_mcu_pkg.sv ====
package jpeg_mcu_pkg;

    // one sample, one byte lane of a RAM word
    localparam int DW = 8;

    // JPEG level shift, subtracted from every sample before the DCT
    localparam logic [DW-1:0] JPEG_BIAS = DW'(128);

    // largest supported frame
    localparam int SENSOR_X_SIZE = 720;
    localparam int SENSOR_Y_SIZE = 720;

    // pixel and line counter widths
    localparam int X_W = $clog2(SENSOR_X_SIZE);
    localparam int Y_W = $clog2(SENSOR_Y_SIZE);

    // luma strip buffer
    // two halves of 16 lines, each line 90 words of 8 pixels
    localparam int Y_BUF_DEPTH = 2 * 16 * (SENSOR_X_SIZE / 8);

    // chroma strip buffer
    // two halves of 8 chroma lines, U and V interleaved on the address lsb
    localparam int UV_BUF_DEPTH = 2 * 2 * 8 * (SENSOR_X_SIZE / 16);

    // RAM address widths, 12 and 11 bits
    localparam int Y_AW  = $clog2(Y_BUF_DEPTH);
    localparam int UV_AW = $clog2(UV_BUF_DEPTH);

    // horizontal and vertical 16x16 block counters
    localparam int BLK_W = $clog2(SENSOR_X_SIZE / 16);

    // 4:2:0 block is Y0 Y1 Y2 Y3 U V
    localparam int MCUS_PER_BLOCK = 6;

endpackage

// ==== design/line_ram_be.sv ====
// dual-port strip buffer RAM
// byte-lane writes, registered read port
module line_ram_be
    import jpeg_mcu_pkg::*;
#(
    parameter int DEPTH = Y_BUF_DEPTH,
    parameter int AW    = Y_AW
) (
    input  logic            clk,
    ram_wr_if.sink          wr_port,
    input  logic [AW-1:0]   ra_i,
    input  logic            re_i,
    output logic [8*DW-1:0] rd_o
);

    logic [8*DW-1:0] mem [DEPTH];

    // write side, only the enabled lanes are touched
    always_ff @(posedge clk) begin
        if (wr_port.we) begin
            for (int i = 0; i < 8; i++) begin
                if (wr_port.be[i]) begin
                    mem[wr_port.addr][i*DW +: DW] <= wr_port.data[i*DW +: DW];
                end
            end
        end
    end

    // read side
    // rd_o keeps the last word while re_i is low, the reader relies on it during hold
    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_o <= mem[ra_i];
        end
    end

    // address generators on both sides must stay inside the array
    a_wr_addr_range: assert property (@(posedge clk)
        wr_port.we |-> (int'(wr_port.addr) < DEPTH))
        else $error("write address beyond RAM depth");

    a_rd_addr_range: assert property (@(posedge clk)
        re_i |-> (int'(ra_i) < DEPTH))
        else $error("read address beyond RAM depth");

endmodule

// ==== design/mcu_buffer.sv ====
// raster to MCU reorder stage, 4:2:0 only
// writer fills the strip halves, reader drains them as 8-byte MCU rows
module mcu_buffer
    import jpeg_mcu_pkg::*;
(
    input  logic            clk,
    input  logic            resetn,

    // raster input, one component per beat
    input  logic [3*DW-1:0] pix_data_i,
    input  logic [2:0]      pix_valid_i,
    output logic            pix_hold_o,
    input  logic [X_W-1:0]  pixel_count_i,
    input  logic [Y_W-1:0]  line_count_i,

    // frame size minus one
    input  logic [X_W-1:0]  x_size_m1_i,
    input  logic [Y_W-1:0]  y_size_m1_i,

    // MCU row output
    output logic [8*DW-1:0] mcu_row_o,
    output logic            mcu_valid_o,
    input  logic            mcu_hold_i,
    output logic [2:0]      mcu_line_o
);

    logic             strip_done;
    logic             full;
    logic             wsel;

    logic [Y_AW-1:0]  y_ra;
    logic             y_re;
    logic [8*DW-1:0]  y_rd;

    logic [UV_AW-1:0] uv_ra;
    logic             uv_re;
    logic [8*DW-1:0]  uv_rd;

    // write ports, writer to RAM
    ram_wr_if #(.AW(Y_AW))  y_wr ();
    ram_wr_if #(.AW(UV_AW)) uv_wr ();

    pixel_writer u_writer (
        .clk           (clk),
        .resetn        (resetn),
        .pix_data_i    (pix_data_i),
        .pix_valid_i   (pix_valid_i),
        .pixel_count_i (pixel_count_i),
        .line_count_i  (line_count_i),
        .x_size_m1_i   (x_size_m1_i),
        .y_size_m1_i   (y_size_m1_i),
        .full_i        (full),
        .wsel_i        (wsel),
        .pix_hold_o    (pix_hold_o),
        .strip_done_o  (strip_done),
        .y_wr          (y_wr.source),
        .uv_wr         (uv_wr.source)
    );

    // luma, two strips of 16 lines
    line_ram_be #(
        .DEPTH (Y_BUF_DEPTH),
        .AW    (Y_AW)
    ) y_ram (
        .clk     (clk),
        .wr_port (y_wr.sink),
        .ra_i    (y_ra),
        .re_i    (y_re),
        .rd_o    (y_rd)
    );

    // chroma, U and V of two strips
    line_ram_be #(
        .DEPTH (UV_BUF_DEPTH),
        .AW    (UV_AW)
    ) uv_ram (
        .clk     (clk),
        .wr_port (uv_wr.sink),
        .ra_i    (uv_ra),
        .re_i    (uv_re),
        .rd_o    (uv_rd)
    );

    mcu_reader u_reader (
        .clk          (clk),
        .resetn       (resetn),
        .strip_done_i (strip_done),
        .x_size_m1_i  (x_size_m1_i),
        .y_size_m1_i  (y_size_m1_i),
        .full_o       (full),
        .wsel_o       (wsel),
        .y_ra_o       (y_ra),
        .y_re_o       (y_re),
        .y_rd_i       (y_rd),
        .uv_ra_o      (uv_ra),
        .uv_re_o      (uv_re),
        .uv_rd_i      (uv_rd),
        .mcu_hold_i   (mcu_hold_i),
        .mcu_row_o    (mcu_row_o),
        .mcu_valid_o  (mcu_valid_o),
        .mcu_line_o   (mcu_line_o)
    );

endmodule

// ==== design/mcu_reader.sv ====
// strip occupancy and MCU read sequencer
// per 16x16 block the order is Y0 Y1 Y2 Y3 U V, 8 rows each
module mcu_reader
    import jpeg_mcu_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,

    input  logic             strip_done_i,
    input  logic [X_W-1:0]   x_size_m1_i,
    input  logic [Y_W-1:0]   y_size_m1_i,

    // to the writer
    output logic             full_o,
    output logic             wsel_o,

    // luma RAM read port
    output logic [Y_AW-1:0]  y_ra_o,
    output logic             y_re_o,
    input  logic [8*DW-1:0]  y_rd_i,

    // chroma RAM read port
    output logic [UV_AW-1:0] uv_ra_o,
    output logic             uv_re_o,
    input  logic [8*DW-1:0]  uv_rd_i,

    // row output towards the DCT
    input  logic             mcu_hold_i,
    output logic [8*DW-1:0]  mcu_row_o,
    output logic             mcu_valid_o,
    output logic [2:0]       mcu_line_o
);

    localparam int MCU_W = $clog2(MCUS_PER_BLOCK);

    logic [1:0]       wptr;
    logic [1:0]       rptr;
    logic             empty;
    logic             step;
    logic             luma;
    logic             last_row;
    logic             last_mcu;
    logic             last_h_blk;
    logic [BLK_W-1:0] h_blk_m1;

    logic [2:0]       mcu_row;
    logic [MCU_W-1:0] mcu_idx;
    logic [BLK_W-1:0] h_blk;
    logic [MCU_W-1:0] mcu_idx_q;

    // two-entry strip FIFO on 2-bit pointers, bit 1 tells a lap apart
    assign empty  = (wptr == rptr);
    assign full_o = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);
    assign wsel_o = wptr[0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= 2'd0;
        end else if (strip_done_i) begin
            wptr <= wptr + 2'd1;
        end
    end

    // last horizontal block index
    assign h_blk_m1 = x_size_m1_i[X_W-1:4];

    // one row read per cycle while data is buffered and the sink takes it
    assign step       = !mcu_hold_i && !empty;
    assign last_row   = (mcu_row == 3'd7);
    assign last_mcu   = (mcu_idx == MCU_W'(MCUS_PER_BLOCK - 1));
    assign last_h_blk = (h_blk == h_blk_m1);

    // strip is done after V of its last block
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr <= 2'd0;
        end else if (step && last_row && last_mcu && last_h_blk) begin
            rptr <= rptr + 2'd1;
        end
    end

    // nested counters, row, MCU, horizontal block
    always_ff @(posedge clk) begin
        if (!resetn) begin
            mcu_row <= 3'd0;
            mcu_idx <= '0;
            h_blk   <= '0;
        end else if (step) begin
            mcu_row <= mcu_row + 3'd1;
            if (last_row) begin
                if (last_mcu) begin
                    mcu_idx <= '0;
                    if (last_h_blk) begin
                        h_blk <= '0;
                    end else begin
                        h_blk <= h_blk + 1'b1;
                    end
                end else begin
                    mcu_idx <= mcu_idx + 1'b1;
                end
            end
        end
    end

    // MCUs 0..3 are luma, 4 and 5 chroma
    assign luma = (mcu_idx < MCU_W'(MCUS_PER_BLOCK - 2));

    // luma word: block, MCU column, MCU row, line, strip half
    assign y_ra_o = {h_blk, mcu_idx[0], mcu_idx[1], mcu_row, rptr[0]};
    assign y_re_o = step && luma;

    // chroma word: block, line, strip half, U or V
    assign uv_ra_o = {h_blk, mcu_row, rptr[0], mcu_idx[0]};
    assign uv_re_o = step && !luma;

    // MCU index follows the read by one cycle to steer the output mux
    always_ff @(posedge clk) begin
        if (step) begin
            mcu_idx_q  <= mcu_idx;
            mcu_line_o <= mcu_row;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mcu_valid_o <= 1'b0;
        end else if (!mcu_hold_i) begin
            mcu_valid_o <= !empty;
        end
    end

    // RAM output registers double as the row register
    assign mcu_row_o = (mcu_idx_q < MCU_W'(MCUS_PER_BLOCK - 2)) ? y_rd_i : uv_rd_i;

    // writer must respect hold, else a stored strip gets overwritten
    a_no_done_when_full: assert property (@(posedge clk) disable iff (!resetn)
        strip_done_i |-> !full_o)
        else $error("strip completed while both halves are full");

endmodule

// ==== design/pixel_writer.sv ====
// raster beat to strip buffer writer
// one component per beat, level shift applied here
module pixel_writer
    import jpeg_mcu_pkg::*;
(
    input  logic            clk,
    input  logic            resetn,

    // component 0 Y, 1 U, 2 V
    input  logic [3*DW-1:0] pix_data_i,
    input  logic [2:0]      pix_valid_i,
    input  logic [X_W-1:0]  pixel_count_i,
    input  logic [Y_W-1:0]  line_count_i,
    input  logic [X_W-1:0]  x_size_m1_i,
    input  logic [Y_W-1:0]  y_size_m1_i,

    // from the reader
    input  logic            full_i,
    input  logic            wsel_i,

    output logic            pix_hold_o,
    output logic            strip_done_o,

    ram_wr_if.source        y_wr,
    ram_wr_if.source        uv_wr
);

    logic          one_hot;
    logic          accept;
    logic          y_accept;
    logic          uv_accept;
    logic          last_pixel;
    logic          last_line;
    logic [DW-1:0] y_biased;
    logic [DW-1:0] uv_sample;
    logic [DW-1:0] uv_biased;

    // both strip halves busy, producer has to wait
    assign pix_hold_o = full_i;

    // a beat carries exactly one component
    assign one_hot = (pix_valid_i == 3'b001) || (pix_valid_i == 3'b010) ||
                     (pix_valid_i == 3'b100);
    assign accept    = one_hot && !full_i;
    assign y_accept  = accept && pix_valid_i[0];
    assign uv_accept = accept && (pix_valid_i[2:1] != 2'b00);

    // luma, one sample copied to all lanes, lane picked by pixel[2:0]
    assign y_biased = pix_data_i[0 +: DW] - JPEG_BIAS;

    // address is pixel word, line in strip, strip half
    assign y_wr.addr = {pixel_count_i[X_W-1:3], line_count_i[3:0], wsel_i};
    assign y_wr.data = {8{y_biased}};
    assign y_wr.be   = 8'b1 << pixel_count_i[2:0];
    assign y_wr.we   = y_accept;

    // chroma at half resolution
    // lsb of the address splits U from V so both share one RAM
    assign uv_sample = pix_valid_i[2] ? pix_data_i[2*DW +: DW] : pix_data_i[DW +: DW];
    assign uv_biased = uv_sample - JPEG_BIAS;

    assign uv_wr.addr = {pixel_count_i[X_W-1:4], line_count_i[3:1], wsel_i, pix_valid_i[2]};
    assign uv_wr.data = {8{uv_biased}};
    assign uv_wr.be   = 8'b1 << pixel_count_i[3:1];
    assign uv_wr.we   = uv_accept;

    // strip ends with the Y beat of the last pixel on line 15 or the last frame line
    assign last_pixel = (pixel_count_i == x_size_m1_i);
    assign last_line  = (line_count_i[3:0] == 4'hF) || (line_count_i == y_size_m1_i);
    assign strip_done_o = y_accept && last_pixel && last_line;

    // producer must never drive two components at once
    a_valid_onehot0: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(pix_valid_i))
        else $error("more than one component valid in a beat");

    // no edge replication, frame must tile into 16x16 blocks
    a_size_mult16: assert property (@(posedge clk) disable iff (!resetn)
        (x_size_m1_i[3:0] == 4'hF) && (y_size_m1_i[3:0] == 4'hF))
        else $error("frame size is not a multiple of 16");

    // 4:2:0 chroma only sits on even pixel, even line
    a_uv_even_pos: assert property (@(posedge clk) disable iff (!resetn)
        (pix_valid_i[2:1] != 2'b00) |-> (!pixel_count_i[0] && !line_count_i[0]))
        else $error("chroma beat at odd position");

endmodule

// ==== design/ram_wr_if.sv ====
// one byte-enabled RAM write port
interface ram_wr_if
    import jpeg_mcu_pkg::*;
#(
    parameter int AW = Y_AW
);

    logic [AW-1:0]   addr;
    // full 8-lane word, lanes picked by be
    logic [8*DW-1:0] data;
    logic [7:0]      be;
    logic            we;

    // writer side
    modport source (output addr, output data, output be, output we);
    // RAM side
    modport sink (input addr, input data, input be, input we);

endinterface

// ==== dv/mcu_buffer_tb.sv ====
module mcu_buffer_tb
    import jpeg_mcu_pkg::*;
();

    localparam int NUM_FRAMES  = 5;
    // sample arrays are addressed y * 64 + x
    localparam int ROW_PITCH   = 64;
    localparam int FRAME_WORDS = 64 * 64;

    logic            clk;
    logic            resetn;
    logic [3*DW-1:0] pix_data_i;
    logic [2:0]      pix_valid_i;
    logic            pix_hold_o;
    logic [X_W-1:0]  pixel_count_i;
    logic [Y_W-1:0]  line_count_i;
    logic [X_W-1:0]  x_size_m1_i;
    logic [Y_W-1:0]  y_size_m1_i;
    logic [8*DW-1:0] mcu_row_o;
    logic            mcu_valid_o;
    logic            mcu_hold_i;
    logic [2:0]      mcu_line_o;

    // raw frames, chroma only filled at even x and even y
    logic [7:0]  y_smp [NUM_FRAMES][FRAME_WORDS];
    logic [7:0]  u_smp [NUM_FRAMES][FRAME_WORDS];
    logic [7:0]  v_smp [NUM_FRAMES][FRAME_WORDS];
    int          frame_w [NUM_FRAMES];
    int          frame_h [NUM_FRAMES];
    // cumulative row count at the end of each frame
    int          rows_upto [NUM_FRAMES];

    // expected output stream in order
    logic [63:0] exp_row_q [$];
    logic [2:0]  exp_line_q [$];

    int seed         = 34;
    // 0 free running, 1 random, 2 forced high
    int hold_mode    = 0;
    int rows_taken   = 0;
    int total_rows   = 0;
    int total_beats  = 0;
    int limit_cycles = 0;

    mcu_buffer UUT (
        .clk           (clk),
        .resetn        (resetn),
        .pix_data_i    (pix_data_i),
        .pix_valid_i   (pix_valid_i),
        .pix_hold_o    (pix_hold_o),
        .pixel_count_i (pixel_count_i),
        .line_count_i  (line_count_i),
        .x_size_m1_i   (x_size_m1_i),
        .y_size_m1_i   (y_size_m1_i),
        .mcu_row_o     (mcu_row_o),
        .mcu_valid_o   (mcu_valid_o),
        .mcu_hold_i    (mcu_hold_i),
        .mcu_line_o    (mcu_line_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // one MCU row, lane i holds column i, level shift of 128 mod 256
    function automatic logic [63:0] expected_row(input int f, input int strip, input int blk,
                                                 input int mcu, input int row);
        logic [63:0] r;
        int          x0;
        int          y0;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            if (mcu < 4) begin
                // Y0 Y1 on top, Y2 Y3 below
                x0 = blk * 16 + (mcu % 2) * 8 + i;
                y0 = strip * 16 + (mcu / 2) * 8 + row;
                r[i*8 +: 8] = y_smp[f][y0 * ROW_PITCH + x0] - 8'd128;
            end else begin
                // chroma from even pixel, even line
                x0 = blk * 16 + 2 * i;
                y0 = strip * 16 + 2 * row;
                if (mcu == 4) begin
                    r[i*8 +: 8] = u_smp[f][y0 * ROW_PITCH + x0] - 8'd128;
                end else begin
                    r[i*8 +: 8] = v_smp[f][y0 * ROW_PITCH + x0] - 8'd128;
                end
            end
        end
        return r;
    endfunction

    // random frame plus its expected rows, 6 MCUs of 8 rows per block
    task automatic make_frame(input int f, input int w, input int h);
        int rnd;
        frame_w[f] = w;
        frame_h[f] = h;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                rnd = $random(seed);
                y_smp[f][y * ROW_PITCH + x] = rnd[7:0];
                if ((x % 2 == 0) && (y % 2 == 0)) begin
                    rnd = $random(seed);
                    u_smp[f][y * ROW_PITCH + x] = rnd[7:0];
                    rnd = $random(seed);
                    v_smp[f][y * ROW_PITCH + x] = rnd[7:0];
                end
            end
        end
        for (int s = 0; s < h / 16; s++) begin
            for (int b = 0; b < w / 16; b++) begin
                for (int m = 0; m < 6; m++) begin
                    for (int r = 0; r < 8; r++) begin
                        exp_row_q.push_back(expected_row(f, s, b, m, r));
                        exp_line_q.push_back(3'(r));
                    end
                end
            end
        end
        total_beats += w * h + (w * h) / 2;
        total_rows  += (h / 16) * (w / 16) * 48;
        rows_upto[f] = total_rows;
    endtask

    // one component beat, held while the DUT holds
    task automatic send_beat(input int comp, input logic [7:0] sample, input int x, input int y);
        logic [23:0] data;
        @(negedge clk);
        // other lanes carry junk that must be ignored
        data = {~sample, ~sample, ~sample};
        data[comp*8 +: 8] = sample;
        pix_data_i    = data;
        pix_valid_i   = 3'b001 << comp;
        pixel_count_i = X_W'(x);
        line_count_i  = Y_W'(y);
        while (pix_hold_o) begin
            @(negedge clk);
        end
    endtask

    // raster order, U and V follow Y at even positions
    task automatic send_frame(input int f);
        @(negedge clk);
        x_size_m1_i = X_W'(frame_w[f] - 1);
        y_size_m1_i = Y_W'(frame_h[f] - 1);
        for (int y = 0; y < frame_h[f]; y++) begin
            for (int x = 0; x < frame_w[f]; x++) begin
                send_beat(0, y_smp[f][y * ROW_PITCH + x], x, y);
                if ((x % 2 == 0) && (y % 2 == 0)) begin
                    send_beat(1, u_smp[f][y * ROW_PITCH + x], x, y);
                    send_beat(2, v_smp[f][y * ROW_PITCH + x], x, y);
                end
            end
        end
        @(negedge clk);
        pix_valid_i = 3'b000;
    endtask

    task automatic wait_rows(input int n);
        while (rows_taken < n) begin
            @(negedge clk);
        end
    endtask

    // changed after a rising edge, the hold driver reads it on the falling one
    task automatic set_hold_mode(input int m);
        @(posedge clk);
        hold_mode = m;
    endtask

    // both halves fill under output hold, input must stall and output stay frozen
    task automatic check_input_hold();
        while (!pix_hold_o) begin
            @(negedge clk);
        end
        repeat (16) begin
            @(negedge clk);
            compare_value("pix_hold_o", 64'(pix_hold_o), 64'(1));
            compare_value("mcu_valid_o", 64'(mcu_valid_o), 64'(0));
        end
        set_hold_mode(0);
        while (pix_hold_o) begin
            @(negedge clk);
        end
    endtask

    initial begin : hold_drive
        int rnd;
        mcu_hold_i = 1'b0;
        forever begin
            @(negedge clk);
            if (hold_mode == 1) begin
                rnd = $random(seed);
                mcu_hold_i = rnd[0];
            end else begin
                mcu_hold_i = (hold_mode == 2);
            end
        end
    end

    // every row taken on a rising edge is checked against the queue head
    initial begin : row_compare
        logic [63:0] exp_row;
        logic [2:0]  exp_line;
        forever begin
            @(posedge clk);
            if ((mcu_valid_o === 1'b1) && (mcu_hold_i === 1'b0)) begin
                if (exp_row_q.size() == 0) begin
                    report_failure("ERROR: DUT produced a row beyond the expected stream");
                end else begin
                    exp_row  = exp_row_q.pop_front();
                    exp_line = exp_line_q.pop_front();
                    compare_value("mcu_row_o", mcu_row_o, exp_row);
                    compare_value("mcu_line_o", 64'(mcu_line_o), 64'(exp_line));
                    rows_taken++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        report_failure("ERROR: timeout, the MCU output stalled before all rows were taken");
    end

    initial begin : stimulus
        resetn        = 1'b0;
        pix_data_i    = '0;
        pix_valid_i   = 3'b000;
        pixel_count_i = '0;
        line_count_i  = '0;
        x_size_m1_i   = X_W'(31);
        y_size_m1_i   = Y_W'(31);
        make_frame(0, 32, 32);
        make_frame(1, 32, 32);
        make_frame(2, 32, 48);
        make_frame(3, 48, 16);
        make_frame(4, 32, 32);
        limit_cycles = 4 * total_beats + total_rows + 2000;

        repeat (5) @(posedge clk);
        @(negedge clk);
        compare_value("mcu_valid_o", 64'(mcu_valid_o), 64'(0));
        compare_value("pix_hold_o", 64'(pix_hold_o), 64'(0));
        resetn = 1'b1;
        @(negedge clk);
        compare_value("mcu_valid_o", 64'(mcu_valid_o), 64'(0));
        compare_value("pix_hold_o", 64'(pix_hold_o), 64'(0));

        // free running, then random output stalls on the next frame
        send_frame(0);
        set_hold_mode(1);
        send_frame(1);
        wait_rows(rows_upto[1]);

        // output held while two strips land, third strip written after release
        set_hold_mode(2);
        fork
            send_frame(2);
            check_input_hold();
        join
        wait_rows(rows_upto[2]);

        // size changes only once the previous frame is drained
        send_frame(3);
        wait_rows(rows_upto[3]);
        set_hold_mode(1);
        send_frame(4);
        wait_rows(total_rows);

        // idle tail, any extra row fails in the comparator
        // drained buffer leaves the output idle and the input open
        repeat (20) @(negedge clk);
        compare_value("mcu_valid_o", 64'(mcu_valid_o), 64'(0));
        compare_value("pix_hold_o", 64'(pix_hold_o), 64'(0));
        $display("Test passed");
        $finish;
    end

endmodule

// ==== mcu_buffer.f ====
design/jpeg_mcu_pkg.sv
design/ram_wr_if.sv
design/line_ram_be.sv
design/pixel_writer.sv
design/mcu_reader.sv
design/mcu_buffer.sv
dv/mcu_buffer_tb.sv
